//--- hdl/sme_pkg.sv
package sme_pkg;

	//////////////////////////////////////////////////////////////////////
	// character types and special characters
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0] char_t;       // one ascii character
	typedef logic [5:0] match_idx_t;  // reported start position

	localparam char_t CHAR_SPACE  = 8'h20;
	localparam char_t CHAR_DOT    = 8'h2E;  // any single character
	localparam char_t CHAR_HAT    = 8'h5E;  // start anchor, first char only
	localparam char_t CHAR_DOLLAR = 8'h24;  // end anchor, last char only

	//////////////////////////////////////////////////////////////////////
	// control phases
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_STR_LOAD,
		ST_WAIT,
		ST_PAT_LOAD,
		ST_SCAN,
		ST_REPORT
	} sme_state_e;

	typedef struct packed {
		logic head;  // pattern began with ^
		logic tail;  // pattern ended with $
	} anchor_flags_t;

	typedef struct packed {
		logic       found;
		match_idx_t index;  // zero when nothing found
	} sme_result_t;

endpackage

//--- hdl/sme_ctrl.sv
`timescale 1ns/1ns

module sme_ctrl import sme_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        isstring,
	input  logic        ispattern,
	input  logic        scan_done,
	input  sme_result_t result,
	output logic        str_load,
	output logic        pat_load,
	output logic        scan_start,
	output logic        out_valid,
	output logic        match,
	output match_idx_t  match_index
);

	sme_state_e state;
	sme_state_e state_nxt;

	// strobes are only honoured outside the scan and report phases
	assign str_load = isstring && (state == ST_IDLE || state == ST_STR_LOAD
		|| state == ST_WAIT);
	assign pat_load = ispattern && !isstring && (state == ST_IDLE
		|| state == ST_STR_LOAD || state == ST_WAIT || state == ST_PAT_LOAD);

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				if (isstring)
					state_nxt = ST_STR_LOAD;
				else if (ispattern)
					state_nxt = ST_PAT_LOAD;  // reuse stored string
			end
			ST_STR_LOAD:
			begin
				if (isstring)
					state_nxt = ST_STR_LOAD;
				else if (ispattern)
					state_nxt = ST_PAT_LOAD;
				else
					state_nxt = ST_WAIT;
			end
			ST_WAIT:
			begin
				if (isstring)
					state_nxt = ST_STR_LOAD;  // string replaced before any pattern
				else if (ispattern)
					state_nxt = ST_PAT_LOAD;
			end
			ST_PAT_LOAD:
			begin
				if (!ispattern)
					state_nxt = ST_SCAN;
			end
			ST_SCAN:
			begin
				if (scan_done)
					state_nxt = ST_REPORT;
			end
			ST_REPORT:
				state_nxt = ST_IDLE;  // single report cycle
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state       <= ST_IDLE;
			scan_start  <= 1'b0;
			out_valid   <= 1'b0;
			match       <= 1'b0;
			match_index <= '0;
		end
		else
		begin
			state      <= state_nxt;
			scan_start <= (state == ST_PAT_LOAD) && !ispattern;  // entering scan
			if (state == ST_SCAN && scan_done)
			begin
				out_valid   <= 1'b1;
				match       <= result.found;
				match_index <= result.index;
			end
			else
			begin
				out_valid   <= 1'b0;
				match       <= 1'b0;
				match_index <= '0;
			end
		end
	end

endmodule

//--- hdl/sme_string_buf.sv
`timescale 1ns/1ns

module sme_string_buf import sme_pkg::*; #(
	parameter int STR_DEPTH = 32
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             str_load,
	input  char_t                            chardata,
	output char_t [STR_DEPTH-1:0]            str_chars,
	output logic [$clog2(STR_DEPTH+1)-1:0]   str_len
);

	localparam int LEN_W = $clog2(STR_DEPTH+1);

	logic             load_d;   // str_load seen last cycle
	logic             first_char;
	logic [LEN_W-1:0] wr_ptr;
	logic             wr_en;

	// a new string starts over at position zero
	assign first_char = str_load && !load_d;
	assign wr_ptr     = first_char ? '0 : str_len;
	assign wr_en      = str_load && (wr_ptr < STR_DEPTH);  // drop overflow chars

	//////////////////////////////////////////////////////////////////////
	// length and load tracking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			load_d  <= 1'b0;
			str_len <= '0;
		end
		else
		begin
			load_d <= str_load;
			if (wr_en)
				str_len <= wr_ptr + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// character storage
	//////////////////////////////////////////////////////////////////////

	// slots at or past str_len keep stale data, the scanner never looks there
	always_ff @(posedge clk)
	begin
		if (wr_en)
			str_chars[wr_ptr] <= chardata;
	end

endmodule

//--- hdl/sme_pattern_reg.sv
`timescale 1ns/1ns

module sme_pattern_reg import sme_pkg::*; #(
	parameter int PAT_DEPTH = 8
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             pat_load,
	input  char_t                            chardata,
	output anchor_flags_t                    anchors,
	output char_t [PAT_DEPTH-1:0]            body,
	output logic [$clog2(PAT_DEPTH+1)-1:0]   body_len
);

	localparam int LEN_W = $clog2(PAT_DEPTH+1);

	logic             load_d;
	logic             first_char;
	logic             is_hat;      // leading start anchor
	logic             wr_en;
	logic [LEN_W-1:0] wr_ptr;
	logic [LEN_W-1:0] stored_cnt;  // chars kept, trailing $ included
	anchor_flags_t    flags_q;

	assign first_char = pat_load && !load_d;
	assign is_hat     = first_char && (chardata == CHAR_HAT);
	assign wr_ptr     = first_char ? '0 : stored_cnt;
	assign wr_en      = pat_load && !is_hat && (wr_ptr < PAT_DEPTH);

	//////////////////////////////////////////////////////////////////////
	// anchor flags and body length
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			load_d     <= 1'b0;
			stored_cnt <= '0;
			flags_q    <= '0;
		end
		else
		begin
			load_d <= pat_load;
			if (is_hat)
			begin
				flags_q.head <= 1'b1;
				flags_q.tail <= 1'b0;
				stored_cnt   <= '0;
			end
			else if (wr_en)
			begin
				if (first_char)
					flags_q.head <= 1'b0;  // no start anchor this time
				// only the final stored char decides the end anchor
				flags_q.tail <= (chardata == CHAR_DOLLAR);
				stored_cnt   <= wr_ptr + 1'b1;
			end
		end
	end

	// a trailing $ sits in the last slot but is not part of the body
	assign anchors  = flags_q;
	assign body_len = stored_cnt - LEN_W'(flags_q.tail);

	//////////////////////////////////////////////////////////////////////
	// body storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (wr_en)
			body[wr_ptr] <= chardata;
	end

endmodule

//--- hdl/sme_scanner.sv
`timescale 1ns/1ns

module sme_scanner import sme_pkg::*; #(
	parameter int STR_DEPTH = 32,
	parameter int PAT_DEPTH = 8
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             scan_start,
	input  char_t [STR_DEPTH-1:0]            str_chars,
	input  logic [$clog2(STR_DEPTH+1)-1:0]   str_len,
	input  anchor_flags_t                    anchors,
	input  char_t [PAT_DEPTH-1:0]            body,
	input  logic [$clog2(PAT_DEPTH+1)-1:0]   body_len,
	output logic                             scan_done,
	output sme_result_t                      result
);

	localparam int POS_W = $clog2(STR_DEPTH+1);

	logic                 busy;
	logic [POS_W-1:0]     pos;        // start position under test
	logic [POS_W:0]       win_end;    // first position after the window
	logic [PAT_DEPTH-1:0] slot_ok;
	logic                 body_fits;
	logic                 head_ok;
	logic                 tail_ok;
	logic                 fit;
	logic                 last_pos;

	assign win_end = (POS_W+1)'(pos) + (POS_W+1)'(body_len);

	//////////////////////////////////////////////////////////////////////
	// parallel window compare
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < PAT_DEPTH; i++)
	begin : g_slot
		logic [POS_W:0] idx;

		assign idx = (POS_W+1)'(pos) + (POS_W+1)'(i);
		// unused slots pass, dot passes anything including space
		assign slot_ok[i] = (i >= body_len) || (body[i] == CHAR_DOT)
			|| ((idx < STR_DEPTH) && (body[i] == str_chars[idx]));
	end

	assign body_fits = (win_end <= str_len);

	// start anchor needs position 0 or a space just before the window
	assign head_ok = !anchors.head || (pos == '0)
		|| (str_chars[pos - 1'b1] == CHAR_SPACE);

	// end anchor needs the string end or a space just after the window
	assign tail_ok = !anchors.tail || (win_end == str_len)
		|| ((win_end < STR_DEPTH) && (str_chars[win_end] == CHAR_SPACE));

	assign fit      = busy && body_fits && (&slot_ok) && head_ok && tail_ok;
	assign last_pos = (win_end >= str_len);  // later positions cannot fit

	assign scan_done    = busy && (fit || last_pos);
	assign result.found = fit;
	assign result.index = fit ? match_idx_t'(pos) : '0;

	//////////////////////////////////////////////////////////////////////
	// position stepping
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			pos  <= '0;
		end
		else if (scan_start)
		begin
			busy <= 1'b1;
			pos  <= '0;
		end
		else if (scan_done)
			busy <= 1'b0;  // first fit or ran out of positions
		else if (busy)
			pos <= pos + 1'b1;
	end

endmodule

//--- hdl/sme_top.sv
`timescale 1ns/1ns

module sme_top import sme_pkg::*; #(
	parameter int STR_DEPTH = 32,
	parameter int PAT_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  char_t      chardata,
	input  logic       isstring,
	input  logic       ispattern,
	output logic       out_valid,
	output logic       match,
	output match_idx_t match_index
);

	localparam int STR_LEN_W = $clog2(STR_DEPTH+1);
	localparam int PAT_LEN_W = $clog2(PAT_DEPTH+1);

	logic                  str_load;
	logic                  pat_load;
	logic                  scan_start;
	logic                  scan_done;
	sme_result_t           result;
	char_t [STR_DEPTH-1:0] str_chars;
	logic [STR_LEN_W-1:0]  str_len;
	anchor_flags_t         anchors;
	char_t [PAT_DEPTH-1:0] body;
	logic [PAT_LEN_W-1:0]  body_len;

	sme_ctrl i_sme_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.isstring    (isstring),
		.ispattern   (ispattern),
		.scan_done   (scan_done),
		.result      (result),
		.str_load    (str_load),
		.pat_load    (pat_load),
		.scan_start  (scan_start),
		.out_valid   (out_valid),
		.match       (match),
		.match_index (match_index)
	);

	sme_string_buf #(.STR_DEPTH(STR_DEPTH)) i_sme_string_buf (
		.clk       (clk),
		.rst_n     (rst_n),
		.str_load  (str_load),
		.chardata  (chardata),
		.str_chars (str_chars),
		.str_len   (str_len)
	);

	sme_pattern_reg #(.PAT_DEPTH(PAT_DEPTH)) i_sme_pattern_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.pat_load (pat_load),
		.chardata (chardata),
		.anchors  (anchors),
		.body     (body),
		.body_len (body_len)
	);

	sme_scanner #(.STR_DEPTH(STR_DEPTH), .PAT_DEPTH(PAT_DEPTH)) i_sme_scanner (
		.clk        (clk),
		.rst_n      (rst_n),
		.scan_start (scan_start),
		.str_chars  (str_chars),
		.str_len    (str_len),
		.anchors    (anchors),
		.body       (body),
		.body_len   (body_len),
		.scan_done  (scan_done),
		.result     (result)
	);

endmodule

//--- testbench/sme_ref_model.svh
`ifndef SME_REF_MODEL_SVH
`define SME_REF_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// random numbers
//////////////////////////////////////////////////////////////////////

logic [31:0] lcg_state = 32'h4b3b;

function automatic int rand_below(input int bound);
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return int'(lcg_state[30:16]) % bound;  // upper bits, better spread
endfunction

// letters a, b, c and plenty of spaces for the anchors
function automatic char_t rand_char();
	case (rand_below(8))
		0, 1, 2: return "a";
		3, 4:    return "b";
		5:       return "c";
		default: return " ";
	endcase
endfunction

//////////////////////////////////////////////////////////////////////
// expected result of pat_buf against str_buf
//////////////////////////////////////////////////////////////////////

function automatic sme_result_t ref_match();
	sme_result_t res;
	logic        head;
	logic        tail;
	logic        ok;
	int          first;
	int          blen;
	int          p;
	int          k;
	res   = '0;
	head  = (pat_len > 0) && (pat_buf[0] == "^");
	first = head ? 1 : 0;
	tail  = (pat_len > first) && (pat_buf[pat_len-1] == "$");
	blen  = pat_len - first - (tail ? 1 : 0);  // body without anchors
	for (p = 0; (blen > 0) && (p + blen <= str_len); p++)
	begin
		ok = 1'b1;
		for (k = 0; k < blen; k++)
			if (pat_buf[first+k] != "." && pat_buf[first+k] != str_buf[p+k])
				ok = 1'b0;
		if (head && p > 0 && str_buf[p-1] != " ")
			ok = 1'b0;
		if (tail && (p + blen < str_len) && str_buf[p+blen] != " ")
			ok = 1'b0;
		if (ok && !res.found)
		begin
			res.found = 1'b1;
			res.index = match_idx_t'(p);  // lowest fitting start
		end
	end
	return res;
endfunction

`endif

//--- testbench/tb_sme.sv
`timescale 1ns/1ns

module tb_sme import sme_pkg::*; ();

	localparam int STR_DEPTH  = 32;
	localparam int PAT_DEPTH  = 8;
	localparam int N_DIRECTED = 18;
	localparam int N_RANDOM   = 200;
	localparam int N_TESTS    = N_DIRECTED + N_RANDOM + N_RANDOM / 4;
	localparam int TIMEOUT    = N_TESTS * (32 + 8 + 40);
	localparam int MAX_LAT    = STR_DEPTH + 3;

	logic       clk;
	logic       rst_n;
	char_t      chardata;
	logic       isstring;
	logic       ispattern;
	logic       out_valid;
	logic       match;
	match_idx_t match_index;

	char_t str_buf[STR_DEPTH];    // string as last sent
	int    str_len;
	char_t pat_buf[PAT_DEPTH];    // anchors included
	int    pat_len;
	logic  awaiting;              // a result is due
	logic  valid_d;
	int    cycle_cnt = 0;
	int    checks = 0;
	int    value_errs = 0;
	int    proto_errs = 0;

	`include "sme_ref_model.svh"

	sme_top i_sme_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.chardata    (chardata),
		.isstring    (isstring),
		.ispattern   (ispattern),
		.out_valid   (out_valid),
		.match       (match),
		.match_index (match_index)
	);

	always #2 clk = ~clk;

	task automatic log_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("FAIL %s expected %0h got %0h", name, exp, got);
		value_errs++;
	endtask

	task automatic log_protocol(input string what);
		$display("protocol error: %s", what);
		proto_errs++;
	endtask

	task automatic print_counts();
		$display("checks %0d, value errors %0d, protocol errors %0d", checks, value_errs,
			proto_errs);
	endtask

	//////////////////////////////////////////////////////////////////////
	// output protocol, sampled mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!rst_n)
			assert (out_valid === 1'b0) else log_value("out_valid", 0, out_valid);
		if (out_valid !== 1'b1)
		begin
			assert (match === 1'b0) else log_value("match", 0, match);
			assert (match_index === '0) else log_value("match_index", 0, match_index);
		end
		assert (!(out_valid && valid_d)) else log_protocol("out_valid high for two cycles");
		assert (!out_valid || awaiting) else log_protocol("out_valid with no pattern sent");
		valid_d = out_valid;
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT)
		begin
			$display("timeout: run still going after %0d cycles", TIMEOUT);
			print_counts();
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic load_string(input string s);
		int i;
		str_len = s.len();
		for (i = 0; i < str_len; i++)
			str_buf[i] = s[i];
	endtask

	task automatic load_pattern(input string p);
		int i;
		pat_len = p.len();
		for (i = 0; i < pat_len; i++)
			pat_buf[i] = p[i];
	endtask

	task automatic drive_string();
		int i;
		for (i = 0; i < str_len; i++)
		begin
			@(posedge clk);
			#1;
			isstring = 1'b1;
			chardata = str_buf[i];
		end
		@(posedge clk);
		#1;
		isstring = 1'b0;
		chardata = '0;
		repeat (3) @(posedge clk);  // idle gap before the pattern
	endtask

	// send pat_buf, wait for the result and compare with the model
	task automatic check_pattern();
		sme_result_t exp;
		int          i;
		int          lat;
		exp      = ref_match();
		awaiting = 1'b1;
		for (i = 0; i < pat_len; i++)
		begin
			@(posedge clk);
			#1;
			ispattern = 1'b1;
			chardata  = pat_buf[i];
		end
		@(posedge clk);
		#1;
		ispattern = 1'b0;
		chardata  = '0;
		lat       = 0;
		while (out_valid !== 1'b1 && lat <= MAX_LAT)
		begin
			@(negedge clk);
			lat++;
		end
		assert (out_valid === 1'b1 && lat <= MAX_LAT)
		else log_protocol("no out_valid within STR_DEPTH + 3 cycles of the pattern end");
		if (out_valid === 1'b1)
		begin
			checks++;
			assert (match === exp.found) else log_value("match", exp.found, match);
			assert (match_index === exp.index)
			else log_value("match_index", exp.index, match_index);
		end
		@(posedge clk);
		#1;
		awaiting = 1'b0;
	endtask

	task automatic try_pattern(input string p);
		load_pattern(p);
		check_pattern();
	endtask

	// pattern either random or cut from the string, anchors now and then
	task automatic make_random_pattern();
		logic head;
		logic tail;
		logic cut;
		int   blen;
		int   start;
		int   i;
		head    = (rand_below(4) == 0);
		tail    = (rand_below(4) == 0);
		cut     = (rand_below(2) == 0);
		blen    = 1 + rand_below(PAT_DEPTH - int'(head) - int'(tail));  // whole pattern fits
		start   = rand_below(str_len);
		pat_len = 0;
		if (head)
		begin
			pat_buf[0] = "^";
			pat_len    = 1;
		end
		for (i = 0; i < blen; i++)
		begin
			if (cut && (start + i < str_len) && rand_below(5) != 0)
				pat_buf[pat_len] = str_buf[start+i];
			else if (rand_below(4) == 0)
				pat_buf[pat_len] = ".";
			else
				pat_buf[pat_len] = rand_char();
			pat_len++;
		end
		if (tail)
		begin
			pat_buf[pat_len] = "$";
			pat_len++;
		end
	endtask

	initial
	begin
		int n;
		int i;
		clk       = 1'b0;
		rst_n     = 1'b0;
		chardata  = '0;
		isstring  = 1'b0;
		ispattern = 1'b0;
		awaiting  = 1'b0;
		valid_d   = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);

		// literals, dot and anchors on one string
		load_string("abcabc dab cab");
		drive_string();
		try_pattern("cab");
		try_pattern("xyz");
		try_pattern("c.d");
		try_pattern(" cab.");  // body runs past the end
		try_pattern("^cab");
		try_pattern("ab$");
		try_pattern("^ab$");
		try_pattern("^d.b$");
		try_pattern("a$b");
		try_pattern("b^c");

		// shorter string must hide the old tail
		load_string("ab");
		drive_string();
		try_pattern("cab");
		try_pattern("b$");
		try_pattern("^a");
		try_pattern("abc");
		try_pattern("..");

		// full length, last position and no fit, longest scans
		load_string("aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaab");
		drive_string();
		try_pattern("b");
		try_pattern("c");
		try_pattern("^......$");

		for (n = 0; n < N_RANDOM; n++)
		begin
			str_len = 1 + rand_below(STR_DEPTH);
			for (i = 0; i < str_len; i++)
				str_buf[i] = rand_char();
			drive_string();
			make_random_pattern();
			check_pattern();
			if (n % 4 == 0)
			begin
				make_random_pattern();  // reuse the stored string
				check_pattern();
			end
		end

		print_counts();
		if (value_errs == 0 && proto_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- files.f
+incdir+testbench
hdl/sme_pkg.sv
hdl/sme_ctrl.sv
hdl/sme_string_buf.sv
hdl/sme_pattern_reg.sv
hdl/sme_scanner.sv
hdl/sme_top.sv
testbench/tb_sme.sv

//--- Bender.yml
package:
  name: sme

sources:
  - files:
      - hdl/sme_pkg.sv
      - hdl/sme_ctrl.sv
      - hdl/sme_string_buf.sv
      - hdl/sme_pattern_reg.sv
      - hdl/sme_scanner.sv
      - hdl/sme_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_sme.sv
